// ==== src/usbProtocolPkg.sv ====
package usbProtocolPkg;

    // One packet byte, sent LSB first
    typedef logic [7:0] usbByte;

    typedef logic [15:0] crcWord;

    // Wire form, check nibble in the upper half
    typedef enum logic [7:0] {
        pidAck   = 8'hD2,
        pidNak   = 8'h5A,
        pidStall = 8'h1E,
        pidData0 = 8'hC3,
        pidData1 = 8'h4B,
        pidData2 = 8'h87,
        pidMdata = 8'h0F
    } usbPid;

    // Decodes from KJKJKJKK
    localparam usbByte syncPattern = 8'h80;

    // CRC16 kept in reflected form, x^16 + x^15 + x^2 + 1
    localparam crcWord crcPoly     = 16'hA001;
    localparam crcWord crcInit     = 16'hFFFF;
    localparam crcWord crcResidual = 16'hB001;

    function automatic logic pidCheckOk(usbByte pid);
        return pid[7:4] == ~pid[3:0];
    endfunction

    // Only DATA0/1/2 and MDATA carry CRC16
    function automatic logic isDataPid(usbByte pid);
        return pid[1:0] == 2'b11;
    endfunction

endpackage

// ==== src/lineCodingPkg.sv ====
package lineCodingPkg;

    // Encoded as {D+, D-}
    typedef enum logic [1:0] {
        lineSe0 = 2'b00,
        lineK   = 2'b01,
        lineJ   = 2'b10,
        lineSe1 = 2'b11
    } lineState;

    localparam int bitCountWidth = 3;

    typedef logic [bitCountWidth-1:0] bitIndex;

    // Length of the current run of ones
    typedef logic [2:0] onesCount;

    // A zero follows six ones
    localparam onesCount stuffLimit = 3'd6;

    // Four clk48 cycles per bit at full speed
    localparam int defaultDivideLog2 = 2;

endpackage

// ==== src/usbCrc.sv ====
`timescale 1ns/1ns

module usbCrc (
    input  logic                    clk48,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    shift,
    input  logic                    dataBit,
    output usbProtocolPkg::crcWord  crcValue,
    output logic                    residualOk
);

    import usbProtocolPkg::*;

    crcWord crcReg;
    logic   feedback;

    // Reflected register, so bit 0 is the x^15 term
    assign feedback = crcReg[0] ^ dataBit;

    always_ff @(posedge clk48) begin
        if (reset || clear) begin
            crcReg <= crcInit;
        end else if (shift) begin
            crcReg <= (crcReg >> 1) ^ (feedback ? crcPoly : '0);
        end
    end

    assign crcValue = crcReg;

    // Holds once payload and inverted CRC have both gone through
    assign residualOk = (crcReg == crcResidual);

endmodule

// ==== src/usbTx.sv ====
`timescale 1ns/1ns

module usbTx #(
    parameter int DivideLog2 = lineCodingPkg::defaultDivideLog2
) (
    input  logic                    clk48,
    input  logic                    reset,
    input  logic                    txReqSendPacket,
    input  logic                    txIsLastByte,
    input  logic                    txDataValid,
    input  usbProtocolPkg::usbByte  txData,
    input  usbProtocolPkg::crcWord  txCrcValue,
    output logic                    txAcceptNewData,
    output logic                    sending,
    output logic                    txCrcClear,
    output logic                    txCrcShift,
    output logic                    txCrcBit,
    output logic                    usbDp,
    output logic                    usbDn
);

    import usbProtocolPkg::*;
    import lineCodingPkg::*;

    typedef enum logic [2:0] {idle, sync, payload, crcLow, crcHigh, eop} txState;

    txState                 state;
    logic [DivideLog2-1:0]  divCount;
    usbByte                 byteReg;
    usbByte                 curByte;
    bitIndex                bitIdx;
    onesCount               onesRun;
    logic [1:0]             eopCount;
    logic                   nrziLevel;
    lineState               lineOut;
    logic                   isDataPacket;
    logic                   lastTaken;
    logic                   onPid;
    logic                   advance;
    logic                   stuffNow;
    logic                   emitData;
    logic                   byteDone;
    logic                   dataBit;
    logic                   nextLevel;
    logic                   takeByte;
    logic                   endPayload;

    // CRC bytes come straight from the engine, it is idle by then
    always_comb begin
        case (state)
            crcLow:  curByte = ~txCrcValue[7:0];
            crcHigh: curByte = ~txCrcValue[15:8];
            default: curByte = byteReg;
        endcase
    end

    // Bit boundary, the request itself starts the first SYNC bit
    assign advance    = (state == idle) ? txReqSendPacket : (divCount == '1);
    assign stuffNow   = (onesRun == stuffLimit);
    assign emitData   = advance && !stuffNow && (state != eop);
    assign byteDone   = emitData && (bitIdx == '1);
    assign dataBit    = curByte[bitIdx];
    assign nextLevel  = nrziLevel ^ ~dataBit;
    assign takeByte   = byteDone && ((state == sync) ||
                        ((state == payload) && !lastTaken && txDataValid));
    assign endPayload = byteDone && (state == payload) && !takeByte;

    assign txAcceptNewData = takeByte;
    assign txCrcClear      = (state == idle) && txReqSendPacket;
    assign txCrcShift      = emitData && (state == payload) && !onPid;
    assign txCrcBit        = dataBit;

    always_ff @(posedge clk48) begin
        if (reset) begin
            state     <= idle;
            sending   <= 1'b0;
            divCount  <= '0;
            bitIdx    <= '0;
            onesRun   <= '0;
            eopCount  <= '0;
            nrziLevel <= 1'b1;
            lineOut   <= lineJ;
        end else begin
            divCount <= (state == idle) ? '0 : divCount + 1'b1;
            if (advance && stuffNow) begin
                // Stuffed zero toggles the line
                nrziLevel <= ~nrziLevel;
                lineOut   <= nrziLevel ? lineK : lineJ;
                onesRun   <= '0;
            end else if (advance && (state == eop)) begin
                // SE0, SE0, J, then release
                eopCount <= eopCount + 1'b1;
                lineOut  <= eopCount[1] ? lineJ : lineSe0;
                if (eopCount == 2'd3) begin
                    state     <= idle;
                    sending   <= 1'b0;
                    nrziLevel <= 1'b1;
                end
            end else if (emitData) begin
                nrziLevel <= nextLevel;
                lineOut   <= nextLevel ? lineJ : lineK;
                onesRun   <= dataBit ? onesRun + 1'b1 : '0;
                bitIdx    <= bitIdx + 1'b1;
                if (state == idle) begin
                    state   <= sync;
                    sending <= 1'b1;
                end else if (state == sync && byteDone) begin
                    state <= payload;
                end else if (endPayload) begin
                    state <= isDataPacket ? crcLow : eop;
                end else if (state == crcLow && byteDone) begin
                    state <= crcHigh;
                end else if (state == crcHigh && byteDone) begin
                    state <= eop;
                end
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (state == idle) begin
            byteReg <= syncPattern;
        end else if (takeByte) begin
            byteReg <= txData;
        end
        if (takeByte) begin
            lastTaken <= txIsLastByte;
            onPid     <= (state == sync);
        end
        // Taken from the PID byte
        if (takeByte && state == sync) begin
            isDataPacket <= isDataPid(txData);
        end
    end

    assign usbDp = lineOut[1];
    assign usbDn = lineOut[0];

endmodule

// ==== src/usbRxFifo.sv ====
`timescale 1ns/1ns

module usbRxFifo #(
    parameter int FifoDepthLog2 = 6
) (
    input  logic                    clk48,
    input  logic                    reset,
    input  logic                    writeEnable,
    input  usbProtocolPkg::usbByte  writeData,
    input  logic                    writeLast,
    input  logic                    rxAcceptNewData,
    output logic                    rxDataValid,
    output usbProtocolPkg::usbByte  rxData,
    output logic                    rxIsLastByte
);

    import usbProtocolPkg::*;

    localparam int depth = 2 ** FifoDepthLog2;

    usbByte                  dataMem [depth];
    logic                    lastMem [depth];
    logic [FifoDepthLog2:0]  writePtr;
    logic [FifoDepthLog2:0]  readPtr;
    logic                    full;

    // Extra pointer bit tells full from empty
    assign full = (writePtr[FifoDepthLog2] != readPtr[FifoDepthLog2]) &&
                  (writePtr[FifoDepthLog2-1:0] == readPtr[FifoDepthLog2-1:0]);

    assign rxDataValid  = (writePtr != readPtr);
    assign rxData       = dataMem[readPtr[FifoDepthLog2-1:0]];
    assign rxIsLastByte = lastMem[readPtr[FifoDepthLog2-1:0]];

    always_ff @(posedge clk48) begin
        if (reset) begin
            writePtr <= '0;
            readPtr  <= '0;
        end else begin
            if (writeEnable && !full) writePtr <= writePtr + 1'b1;
            if (rxDataValid && rxAcceptNewData) readPtr <= readPtr + 1'b1;
        end
    end

    always_ff @(posedge clk48) begin
        if (writeEnable && !full) begin
            dataMem[writePtr[FifoDepthLog2-1:0]] <= writeData;
            lastMem[writePtr[FifoDepthLog2-1:0]] <= writeLast;
        end
    end

endmodule

// ==== src/usbRx.sv ====
`timescale 1ns/1ns

module usbRx #(
    parameter int DivideLog2    = lineCodingPkg::defaultDivideLog2,
    parameter int FifoDepthLog2 = 6
) (
    input  logic                    clk48,
    input  logic                    reset,
    input  logic                    usbDp,
    input  logic                    usbDn,
    input  logic                    rxAcceptNewData,
    output logic                    rxDataValid,
    output logic                    rxIsLastByte,
    output usbProtocolPkg::usbByte  rxData,
    output logic                    keepPacket
);

    import usbProtocolPkg::*;
    import lineCodingPkg::*;

    typedef enum logic {hunt, receive} rxState;

    localparam logic [DivideLog2-1:0] halfBit = DivideLog2'(1 << (DivideLog2 - 1));

    rxState                 state;
    logic [1:0]             lineMeta;
    lineState               lineSync;
    lineState               linePrev;
    lineState               lastLevel;
    logic [DivideLog2-1:0]  phase;
    usbByte                 huntReg;
    usbByte                 shiftReg;
    usbByte                 nextShift;
    usbByte                 heldByte;
    usbByte                 fifoData;
    bitIndex                bitIdx;
    onesCount               onesRun;
    logic                   heldValid;
    logic                   fifoWrite;
    logic                   fifoLast;
    logic                   gotPid;
    logic                   pidOk;
    logic                   isData;
    logic                   stuffErr;
    logic                   crcOk;
    logic                   sampleNow;
    logic                   isSe0;
    logic                   rxBit;
    logic                   syncFound;
    logic                   eopNow;
    logic                   dataSample;
    logic                   bitTaken;
    logic                   byteDone;
    logic                   packetGood;

    // Mid-bit, counted from the last transition
    assign sampleNow = (phase == halfBit);
    assign isSe0     = (lineSync == lineSe0);
    // NRZI: no change means a one
    assign rxBit     = (lineSync == lastLevel);
    assign nextShift = {rxBit, shiftReg[7:1]};

    assign syncFound  = sampleNow && !isSe0 && (state == hunt) &&
                        ({rxBit, huntReg[7:1]} == syncPattern);
    assign eopNow     = sampleNow && isSe0 && (state == receive);
    assign dataSample = sampleNow && !isSe0 && (state == receive);
    assign bitTaken   = dataSample && (onesRun != stuffLimit);
    assign byteDone   = bitTaken && (bitIdx == '1);

    assign packetGood = gotPid && pidOk && !stuffErr && (bitIdx == '0) &&
                        (!isData || crcOk);

    usbCrc rxCrc (
        .clk48      (clk48),
        .reset      (reset),
        .clear      (syncFound),
        .shift      (bitTaken && gotPid),
        .dataBit    (rxBit),
        .crcValue   (),
        .residualOk (crcOk)
    );

    always_ff @(posedge clk48) begin
        if (reset) begin
            state      <= hunt;
            lineMeta   <= lineJ;
            lineSync   <= lineJ;
            linePrev   <= lineJ;
            lastLevel  <= lineJ;
            phase      <= '0;
            huntReg    <= '1;
            bitIdx     <= '0;
            onesRun    <= '0;
            heldValid  <= 1'b0;
            fifoWrite  <= 1'b0;
            gotPid     <= 1'b0;
            pidOk      <= 1'b0;
            isData     <= 1'b0;
            stuffErr   <= 1'b0;
            keepPacket <= 1'b0;
        end else begin
            lineMeta   <= {usbDp, usbDn};
            lineSync   <= lineState'(lineMeta);
            linePrev   <= lineSync;
            phase      <= (lineSync != linePrev) ? '0 : phase + 1'b1;
            keepPacket <= eopNow && packetGood;
            // Previous byte moves on once a newer one or the EOP shows up
            fifoWrite  <= (byteDone || eopNow) && heldValid;

            if (sampleNow) lastLevel <= isSe0 ? lineJ : lineSync;

            if (sampleNow && !isSe0 && state == hunt) begin
                huntReg <= syncFound ? '1 : {rxBit, huntReg[7:1]};
            end

            if (syncFound) begin
                // SYNC ends on a one, which counts toward stuffing
                state    <= receive;
                onesRun  <= 3'd1;
                bitIdx   <= '0;
                gotPid   <= 1'b0;
                stuffErr <= 1'b0;
            end else if (eopNow) begin
                state     <= hunt;
                heldValid <= 1'b0;
            end else if (dataSample && !bitTaken) begin
                // Stuffed bit, a one here is seven in a row
                onesRun  <= '0;
                stuffErr <= stuffErr | rxBit;
            end else if (bitTaken) begin
                onesRun <= rxBit ? onesRun + 1'b1 : '0;
                bitIdx  <= bitIdx + 1'b1;
                if (byteDone) begin
                    heldValid <= 1'b1;
                    gotPid    <= 1'b1;
                    if (!gotPid) begin
                        pidOk  <= pidCheckOk(nextShift);
                        isData <= isDataPid(nextShift);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (bitTaken) shiftReg <= nextShift;
        if (byteDone) heldByte <= nextShift;
        if (byteDone || eopNow) fifoData <= heldByte;
        fifoLast <= eopNow;
    end

    usbRxFifo #(
        .FifoDepthLog2 (FifoDepthLog2)
    ) rxFifo (
        .clk48           (clk48),
        .reset           (reset),
        .writeEnable     (fifoWrite),
        .writeData       (fifoData),
        .writeLast       (fifoLast),
        .rxAcceptNewData (rxAcceptNewData),
        .rxDataValid     (rxDataValid),
        .rxData          (rxData),
        .rxIsLastByte    (rxIsLastByte)
    );

endmodule

// ==== src/usbLoopback.sv ====
`timescale 1ns/1ns

module usbLoopback #(
    parameter int DivideLog2    = lineCodingPkg::defaultDivideLog2,
    parameter int FifoDepthLog2 = 6
) (
    input  logic                    clk48,
    input  logic                    reset,
    input  logic                    txReqSendPacket,
    input  logic                    txIsLastByte,
    input  logic                    txDataValid,
    input  usbProtocolPkg::usbByte  txData,
    input  logic                    rxAcceptNewData,
    output logic                    txAcceptNewData,
    output logic                    sending,
    output logic                    rxIsLastByte,
    output logic                    rxDataValid,
    output usbProtocolPkg::usbByte  rxData,
    output logic                    keepPacket
);

    import usbProtocolPkg::*;

    crcWord txCrcValue;
    logic   txCrcClear;
    logic   txCrcShift;
    logic   txCrcBit;
    logic   usbDp;
    logic   usbDn;

    usbTx #(
        .DivideLog2 (DivideLog2)
    ) tx (
        .clk48           (clk48),
        .reset           (reset),
        .txReqSendPacket (txReqSendPacket),
        .txIsLastByte    (txIsLastByte),
        .txDataValid     (txDataValid),
        .txData          (txData),
        .txCrcValue      (txCrcValue),
        .txAcceptNewData (txAcceptNewData),
        .sending         (sending),
        .txCrcClear      (txCrcClear),
        .txCrcShift      (txCrcShift),
        .txCrcBit        (txCrcBit),
        .usbDp           (usbDp),
        .usbDn           (usbDn)
    );

    // Transmit side only needs the running value
    usbCrc txCrc (
        .clk48      (clk48),
        .reset      (reset),
        .clear      (txCrcClear),
        .shift      (txCrcShift),
        .dataBit    (txCrcBit),
        .crcValue   (txCrcValue),
        .residualOk ()
    );

    usbRx #(
        .DivideLog2    (DivideLog2),
        .FifoDepthLog2 (FifoDepthLog2)
    ) rx (
        .clk48           (clk48),
        .reset           (reset),
        .usbDp           (usbDp),
        .usbDn           (usbDn),
        .rxAcceptNewData (rxAcceptNewData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .rxData          (rxData),
        .keepPacket      (keepPacket)
    );

endmodule

// ==== verif/usbPacketModel.svh ====
`ifndef USB_PACKET_MODEL_SVH
`define USB_PACKET_MODEL_SVH

// Register after the payload, reflected USB CRC16 started from all ones
function automatic logic [15:0] crc16Of(input usbByte payload[$]);
    logic [15:0] crc;
    logic        feedback;
    int          i;
    int          b;
    crc = 16'hFFFF;
    for (i = 0; i < payload.size(); i++) begin
        // Bytes go onto the line LSB first
        for (b = 0; b < 8; b++) begin
            feedback = crc[0] ^ payload[i][b];
            crc      = crc >> 1;
            if (feedback) begin
                crc = crc ^ 16'hA001;
            end
        end
    end
    return crc;
endfunction

// Bytes the receiver hands out for one sent packet
function automatic void expectedStream(input usbByte sent[$], input int cut,
                                       output usbByte stream[$]);
    usbByte      payload[$];
    logic [15:0] crc;
    int          taken;
    int          i;
    // A low txDataValid at a take ends the payload before that byte
    taken   = (cut >= 1 && cut < sent.size()) ? cut : sent.size();
    stream  = {};
    payload = {};
    for (i = 0; i < taken; i++) begin
        stream.push_back(sent[i]);
        if (i > 0) begin
            payload.push_back(sent[i]);
        end
    end
    // Data PIDs have both low bits set and carry the inverted CRC, low byte first
    if (sent[0][1:0] == 2'b11) begin
        crc = crc16Of(payload);
        stream.push_back(~crc[7:0]);
        stream.push_back(~crc[15:8]);
    end
endfunction

// Clean line, so only the PID check nibble decides
function automatic bit packetIsGood(input usbByte pid);
    return pid[7:4] == ~pid[3:0];
endfunction

// Upper bound of line bits: SYNC, bytes, stuffing, EOP and the idle gap
function automatic int lineBits(input int bytes);
    return 8 + 8 * bytes + (8 * bytes + 8) / 6 + 5;
endfunction

`endif

// ==== verif/usbLoopbackTb.sv ====
`timescale 1ns/1ns

module usbLoopbackTb;

    import usbProtocolPkg::*;

    `include "usbPacketModel.svh"

    localparam int DivideLog2    = 2;
    localparam int FifoDepthLog2 = 6;

    logic   clk48;
    logic   reset;
    logic   txReqSendPacket;
    logic   txIsLastByte;
    logic   txDataValid;
    usbByte txData;
    logic   rxAcceptNewData;
    logic   txAcceptNewData;
    logic   sending;
    logic   rxIsLastByte;
    logic   rxDataValid;
    usbByte rxData;
    logic   keepPacket;

    // Sent packets, flattened, with start, length and cut index
    usbByte sentBytes[$];
    int     sentStart[$];
    int     sentLen[$];
    int     sentCut[$];
    bit     sentThrottle[$];

    usbByte expData[$];
    bit     expLast[$];
    bit     expGood[$];

    bit     throttle;
    int     keepCount;
    int     totalBits;
    int     watchdogCycles;

    usbLoopback #(
        .DivideLog2    (DivideLog2),
        .FifoDepthLog2 (FifoDepthLog2)
    ) DUT (
        .clk48           (clk48),
        .reset           (reset),
        .txReqSendPacket (txReqSendPacket),
        .txIsLastByte    (txIsLastByte),
        .txDataValid     (txDataValid),
        .txData          (txData),
        .rxAcceptNewData (rxAcceptNewData),
        .txAcceptNewData (txAcceptNewData),
        .sending         (sending),
        .rxIsLastByte    (rxIsLastByte),
        .rxDataValid     (rxDataValid),
        .rxData          (rxData),
        .keepPacket      (keepPacket)
    );

    initial begin
        clk48 = 1'b0;
        forever #5 clk48 = ~clk48;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            reportFailure($sformatf("error %s: expected 0x%0h, actual 0x%0h",
                                    testName, expected, actual));
        end
    endtask

    function automatic void addPacket(input usbByte sent[$], input int cut, input bit slow);
        usbByte stream[$];
        int     i;
        sentStart.push_back(sentBytes.size());
        sentLen.push_back(sent.size());
        sentCut.push_back(cut);
        sentThrottle.push_back(slow);
        for (i = 0; i < sent.size(); i++) begin
            sentBytes.push_back(sent[i]);
        end
        expectedStream(sent, cut, stream);
        for (i = 0; i < stream.size(); i++) begin
            expData.push_back(stream[i]);
            expLast.push_back(i == stream.size() - 1);
        end
        expGood.push_back(packetIsGood(sent[0]));
        totalBits += lineBits(stream.size());
    endfunction

    function automatic void randomDataPacket(input usbByte pid, input int len, input int cut,
                                             input bit slow);
        usbByte pkt[$];
        int     i;
        pkt.push_back(pid);
        for (i = 0; i < len; i++) begin
            pkt.push_back(usbByte'($urandom));
        end
        addPacket(pkt, cut, slow);
    endfunction

    function automatic void filledPacket(input usbByte pid, input int len, input usbByte value,
                                         input bit slow);
        usbByte pkt[$];
        int     i;
        pkt.push_back(pid);
        for (i = 0; i < len; i++) begin
            pkt.push_back(value);
        end
        addPacket(pkt, 0, slow);
    endfunction

    task automatic buildTests();
        usbByte dataPids[4];
        usbByte handshakes[3];
        usbByte pkt[$];
        int     i;
        int     len;
        dataPids   = '{pidData0, pidData1, pidData2, pidMdata};
        handshakes = '{pidAck, pidNak, pidStall};
        for (i = 0; i < 3; i++) begin
            pkt = {};
            pkt.push_back(handshakes[i]);
            addPacket(pkt, 0, 1'b0);
        end
        // Empty and full-size payloads, then random lengths
        randomDataPacket(pidData0, 0, 0, 1'b0);
        randomDataPacket(pidData1, 32, 0, 1'b0);
        for (i = 0; i < 6; i++) begin
            randomDataPacket(dataPids[i % 4], $urandom_range(32, 0), 0, 1'b0);
        end
        // Long runs of ones for the stuffing logic
        filledPacket(pidData0, 16, 8'hFF, 1'b0);
        filledPacket(pidMdata, 32, 8'hFF, 1'b0);
        pkt = {};
        pkt.push_back(pidData1);
        pkt.push_back(8'h7F);
        pkt.push_back(8'hFE);
        pkt.push_back(8'hFF);
        pkt.push_back(8'h3F);
        pkt.push_back(8'hFC);
        pkt.push_back(8'hFF);
        addPacket(pkt, 0, 1'b0);
        // Receive side stalls at random
        for (i = 0; i < 6; i++) begin
            randomDataPacket(dataPids[i % 4], $urandom_range(32, 0), 0, 1'b1);
        end
        filledPacket(pidData2, 24, 8'hFF, 1'b1);
        // One high nibble bit flipped breaks the check nibble
        for (i = 0; i < 4; i++) begin
            randomDataPacket(dataPids[i] ^ (8'h10 << $urandom_range(3, 0)),
                             $urandom_range(8, 0), 0, 1'b0);
        end
        randomDataPacket(pidNak ^ 8'h40, 0, 0, 1'b1);
        // Early payload end, cut index counts the PID as byte 0
        for (i = 0; i < 6; i++) begin
            len = $urandom_range(32, 2);
            randomDataPacket(dataPids[i % 4], len, $urandom_range(len, 1), i[0]);
        end
    endtask

    task automatic presentByte(input int base, input int len, input int cut, input int idx);
        if (idx < len) begin
            txData       = sentBytes[base + idx];
            txIsLastByte = (idx == len - 1);
            txDataValid  = (idx != cut);
        end else begin
            txData       = '0;
            txIsLastByte = 1'b0;
            txDataValid  = 1'b0;
        end
    endtask

    task automatic sendPacket(input int p);
        int base;
        int len;
        int cut;
        int idx;
        bit taken;
        base     = sentStart[p];
        len      = sentLen[p];
        cut      = sentCut[p];
        throttle = sentThrottle[p];
        @(negedge clk48);
        while (sending) begin
            @(negedge clk48);
        end
        idx = 0;
        presentByte(base, len, cut, idx);
        txReqSendPacket = 1'b1;
        @(negedge clk48);
        txReqSendPacket = 1'b0;
        // A take seen here happens at the coming rising edge
        while (sending) begin
            taken = txAcceptNewData;
            @(negedge clk48);
            if (taken) begin
                idx++;
                presentByte(base, len, cut, idx);
            end
        end
    endtask

    // Comparison process, also drives back-pressure
    initial begin
        int stretch;
        int pktDone;
        int byteIdx;
        int goodSoFar;
        bit accept;
        bit last;
        rxAcceptNewData = 1'b0;
        stretch         = 0;
        pktDone         = 0;
        byteIdx         = 0;
        goodSoFar       = 0;
        accept          = 1'b1;
        keepCount       = 0;
        forever begin
            @(negedge clk48);
            if (keepPacket === 1'b1) begin
                keepCount++;
            end
            if (!throttle) begin
                accept  = 1'b1;
                stretch = 0;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                accept  = !accept;
                stretch = accept ? $urandom_range(6, 1) : $urandom_range(12, 1);
            end
            rxAcceptNewData = accept;
            if (reset === 1'b0 && rxDataValid === 1'b1 && accept) begin
                if (expData.size() == 0) begin
                    reportFailure("A byte arrived that no sent packet accounts for");
                end else begin
                    checkValue($sformatf("packet %0d byte %0d data", pktDone, byteIdx),
                               32'(expData[0]), 32'(rxData));
                    checkValue($sformatf("packet %0d byte %0d last flag", pktDone, byteIdx),
                               32'(expLast[0]), 32'(rxIsLastByte));
                    last = expLast[0];
                    void'(expData.pop_front());
                    void'(expLast.pop_front());
                    byteIdx++;
                    if (last) begin
                        // keepPacket of this packet comes before its last byte
                        if (expGood[pktDone]) begin
                            goodSoFar++;
                        end
                        checkValue($sformatf("packet %0d keepPacket count", pktDone),
                                   32'(goodSoFar), 32'(keepCount));
                        pktDone++;
                        byteIdx = 0;
                    end
                end
            end
        end
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk48);
        reportFailure("Timeout: the packets did not all arrive in the expected time");
    end

    initial begin
        int p;
        int goodTotal;
        reset           = 1'b1;
        txReqSendPacket = 1'b0;
        txIsLastByte    = 1'b0;
        txDataValid     = 1'b0;
        txData          = '0;
        throttle        = 1'b0;
        totalBits       = 0;
        void'($urandom(29365));
        buildTests();
        // Twice the worst case line time plus slack for stalls
        watchdogCycles = 16 + totalBits * (1 << DivideLog2) * 2 + 2000;
        repeat (16) @(negedge clk48);
        reset = 1'b0;
        for (p = 0; p < sentLen.size(); p++) begin
            sendPacket(p);
        end
        while (expData.size() != 0) begin
            @(negedge clk48);
        end
        repeat (64) @(negedge clk48);
        #1;
        goodTotal = 0;
        for (p = 0; p < expGood.size(); p++) begin
            if (expGood[p]) begin
                goodTotal++;
            end
        end
        checkValue("bytes left after the last packet", 32'(0), 32'(rxDataValid));
        checkValue("keepPacket pulses in total", 32'(goodTotal), 32'(keepCount));
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verif
src/usbProtocolPkg.sv
src/lineCodingPkg.sv
src/usbCrc.sv
src/usbTx.sv
src/usbRxFifo.sv
src/usbRx.sv
src/usbLoopback.sv
verif/usbLoopbackTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f src.f \
    --top-module usbLoopbackTb --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit $status
fi

./obj_dir/VusbLoopbackTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit $status
fi

exit 0
